// File: hbm_addr_bridge.f
+incdir+bench
hdl/hbm_bridge_pkg.sv
hdl/hbm_req_decode.sv
hdl/hbm_req_execute.sv
hdl/hbm_read_result.sv
hdl/hbm_addr_bridge.sv
bench/tb_hbm_addr_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the bridge testbench with verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_hbm_addr_bridge \
  -f hbm_addr_bridge.f -Mdir obj_dir

# the log decides the result, so a fatal exit of the model must not stop the script here
./obj_dir/Vtb_hbm_addr_bridge 2>&1 | tee "$LOG" || true

if grep -qF "*** TEST FAILED ***" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
  echo "simulation ended without a result, see $LOG"
  exit 1
fi
echo "simulation passed"

// File: bench/hbm_ref_model.svh
//////////////////////////////
// reference model for the bridge testbench, included in its top
// address reorders, dma id rule and the outstanding read table
//////////////////////////////

`ifndef HBM_REF_MODEL_SVH
`define HBM_REF_MODEL_SVH

// one entry per table slot
bit                         model_v    [read_slots_c];
logic [dma_id_width_c-1:0]  model_id   [read_slots_c];
logic [ch_addr_width_c-1:0] model_addr [read_slots_c];

// cache ba-bg-ro-co-bo into simulator ro-bg-ba-co-bo
function automatic logic [29:0] cache_to_dram(logic [29:0] c);
  return {c[25:12], c[27:26], c[29:28], c[11:0]};
endfunction

function automatic logic [29:0] dram_to_cache(logic [29:0] d);
  return {d[13:12], d[15:14], d[29:16], d[11:0]};
endfunction

// one ruche bit below the id
function automatic logic [2:0] expected_dma_id(logic [7:0] cord);
  return cord[3:1];
endfunction

function automatic bit table_full();
  bit all_v;
  all_v = 1'b1;
  for (int i = 0; i < read_slots_c; i++) begin
    all_v &= model_v[i];
  end
  return all_v;
endfunction

// lowest free slot takes the read
function automatic void table_alloc(logic [2:0] id, logic [29:0] addr);
  bit placed;
  placed = 1'b0;
  for (int i = 0; i < read_slots_c; i++) begin
    if (!model_v[i] && !placed) begin
      model_v[i]    = 1'b1;
      model_id[i]   = id;
      model_addr[i] = addr;
      placed        = 1'b1;
    end
  end
endfunction

// lowest matching slot is freed
function automatic bit table_release(logic [29:0] addr, output logic [2:0] id);
  bit hit;
  hit = 1'b0;
  id  = '0;
  for (int i = 0; i < read_slots_c; i++) begin
    if (model_v[i] && model_addr[i] == addr && !hit) begin
      hit        = 1'b1;
      id         = model_id[i];
      model_v[i] = 1'b0;
    end
  end
  return hit;
endfunction

`endif

// File: bench/tb_hbm_addr_bridge.sv
//////////////////////////////
// testbench for the hbm address bridge
// checks the dram port, read responses and full_o against
// the reference model
//////////////////////////////

`timescale 1ns/1ps

module tb_hbm_addr_bridge
  import hbm_bridge_pkg::*;
();

  localparam int single_c = 8;
  localparam int burst_c  = 16;
  localparam int rounds_c = 6;
  localparam int writes_c = 120;
  // rough cycle count of all phases
  localparam int stim_cycles_c = 10 + single_c * 3 + burst_c + 30
                                 + rounds_c * 16 + writes_c + 20;
  localparam int margin_ns_c   = 2000;

  logic       clk_i;
  logic       reset_i;
  logic       req_v_i;
  logic       req_write_i;
  wh_header_s req_hdr_i;
  ch_addr_u   req_addr_i;
  logic       dram_req_v_o;
  dram_req_s  dram_req_o;
  logic       done_v_i;
  ch_addr_u   done_addr_i;
  logic       rsp_v_o;
  read_rsp_s  rsp_o;
  logic       full_o;

  int          cycle_count = 0;
  bit          reset_done  = 1'b0;
  int unsigned seed_sink;
  string       test_name   = "reset";
  logic [33:0] exp_req_q[$];
  int          exp_req_cyc_q[$];
  logic [32:0] exp_rsp_q[$];
  int          exp_rsp_cyc_q[$];
  logic [29:0] round_addr [4];

  `include "hbm_ref_model.svh"

  hbm_addr_bridge dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_count <= cycle_count + 1;

  task automatic stop_on_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s: %s expected %h actual %h", test_name, what, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic idle(int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic send_req(logic write, logic [29:0] addr);
    logic [7:0] cord;
    cord        = 8'($urandom);
    req_v_i     = 1'b1;
    req_write_i = write;
    req_hdr_i   = {cord, 2'($urandom), 4'($urandom)};
    req_addr_i  = addr;
    exp_req_q.push_back({write, expected_dma_id(cord), cache_to_dram(addr)});
    exp_req_cyc_q.push_back(cycle_count + 2);
    idle(1);
    req_v_i = 1'b0;
  endtask

  task automatic send_done(logic [29:0] cache_addr);
    done_v_i    = 1'b1;
    done_addr_i = cache_to_dram(cache_addr);
    idle(1);
    done_v_i = 1'b0;
  endtask

  // four distinct reads with the slot number in the low column bits
  task automatic issue_round();
    for (int i = 0; i < 4; i++) begin
      round_addr[i] = (30'($urandom) & ~30'h60) | (30'(i) << 5);
    end
    for (int i = 0; i < 4; i++) begin
      send_req(1'b0, round_addr[i]);
    end
  endtask

  //////////////////////////////
  // compare process
  //////////////////////////////

  initial begin : compare_proc
    logic [2:0]  hit_id;
    logic [33:0] exp_req;
    wait (reset_done);
    forever begin
      @(negedge clk_i);
      check_value("full_o", 64'(table_full()), 64'(full_o));
      if (rsp_v_o) begin
        if (exp_rsp_q.size() == 0) begin
          $display("response came out with no completion outstanding");
          stop_on_failure();
        end else begin
          check_value("response cycle", 64'(exp_rsp_cyc_q.pop_front()), 64'(cycle_count));
          check_value("response", 64'(exp_rsp_q.pop_front()), 64'(rsp_o));
        end
      end
      // release before alloc like the table
      if (done_v_i) begin
        if (!table_release(dram_to_cache(done_addr_i), hit_id)) begin
          $display("completion was driven for an address that is not outstanding");
          stop_on_failure();
        end else begin
          exp_rsp_q.push_back({hit_id, dram_to_cache(done_addr_i)});
          exp_rsp_cyc_q.push_back(cycle_count + 1);
        end
      end
      if (dram_req_v_o) begin
        if (exp_req_q.size() == 0) begin
          $display("DRAM request came out that was never sent");
          stop_on_failure();
        end else begin
          exp_req = exp_req_q.pop_front();
          check_value("request cycle", 64'(exp_req_cyc_q.pop_front()), 64'(cycle_count));
          check_value("dram request", 64'(exp_req), 64'(dram_req_o));
          // only reads take a slot in the model
          if (!exp_req[33]) begin
            table_alloc(exp_req[32:30], dram_to_cache(exp_req[29:0]));
          end
        end
      end
    end
  end

  initial begin : watchdog_proc
    #(stim_cycles_c * 10 + margin_ns_c);
    $display("watchdog expired, the tests did not finish in time");
    stop_on_failure();
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin : main_proc
    int          pick;
    logic [29:0] tmp;
    seed_sink   = $urandom(32'hc246_0b28);
    reset_i     = 1'b1;
    req_v_i     = 1'b0;
    req_write_i = 1'b0;
    req_hdr_i   = '0;
    req_addr_i  = '0;
    done_v_i    = 1'b0;
    done_addr_i = '0;
    repeat (4) @(posedge clk_i);
    #1;
    reset_i    = 1'b0;
    reset_done = 1'b1;
    check_value("dram_req_v_o", 64'd0, 64'(dram_req_v_o));
    check_value("rsp_v_o", 64'd0, 64'(rsp_v_o));
    check_value("full_o", 64'd0, 64'(full_o));

    test_name = "single requests";
    repeat (single_c) begin
      send_req(1'b1, 30'($urandom));
      idle(2);
    end
    test_name = "back to back";
    repeat (burst_c) send_req(1'b1, 30'($urandom));
    idle(4);

    test_name = "full flag";
    issue_round();
    idle(1);
    check_value("full_o before last issue", 64'd0, 64'(full_o));
    idle(1);
    check_value("full_o after four reads", 64'd1, 64'(full_o));
    send_done(round_addr[0]);
    check_value("full_o after one completion", 64'd0, 64'(full_o));
    for (int i = 1; i < 4; i++) send_done(round_addr[i]);
    idle(3);

    test_name = "random completion order";
    repeat (rounds_c) begin
      issue_round();
      idle(3);
      for (int i = 3; i > 0; i--) begin
        pick             = int'($urandom_range(i, 0));
        tmp              = round_addr[i];
        round_addr[i]    = round_addr[pick];
        round_addr[pick] = tmp;
      end
      for (int i = 0; i < 4; i++) send_done(round_addr[i]);
      idle(2);
    end

    test_name = "write stream";
    repeat (writes_c) begin
      send_req(1'b1, 30'($urandom));
      check_value("full_o", 64'd0, 64'(full_o));
    end
    idle(6);

    if (exp_req_q.size() != 0 || exp_rsp_q.size() != 0) begin
      $display("some requests or responses never came out of the DUT");
      stop_on_failure();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: hdl/hbm_addr_bridge.sv
//////////////////////////////
// bridge from the cache dma interface to one hbm2 channel
// decode, execute and read result stages in a row
//////////////////////////////

`timescale 1ns/1ps

module hbm_addr_bridge
  import hbm_bridge_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,

  // requester side
  input  logic       req_v_i,
  input  logic       req_write_i,
  input  wh_header_s req_hdr_i,
  input  ch_addr_u   req_addr_i,

  // dram request port
  output logic       dram_req_v_o,
  output dram_req_s  dram_req_o,

  // read completion from dram
  input  logic       done_v_i,
  input  ch_addr_u   done_addr_i,

  // response to the cache side
  output logic       rsp_v_o,
  output read_rsp_s  rsp_o,
  output logic       full_o
);

  logic     dec_v;
  dma_req_s dec_req;

  hbm_req_decode decode_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (req_v_i),
    .req_write_i (req_write_i),
    .req_hdr_i   (req_hdr_i),
    .req_addr_i  (req_addr_i),
    .dec_v_o     (dec_v),
    .dec_req_o   (dec_req)
  );

  hbm_req_execute execute_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .dec_v_i      (dec_v),
    .dec_req_i    (dec_req),
    .dram_req_v_o (dram_req_v_o),
    .dram_req_o   (dram_req_o)
  );

  // issue strobe straight off the execute output register
  hbm_read_result result_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .issue_v_i   (dram_req_v_o),
    .issue_req_i (dram_req_o),
    .done_v_i    (done_v_i),
    .done_addr_i (done_addr_i),
    .rsp_v_o     (rsp_v_o),
    .rsp_o       (rsp_o),
    .full_o      (full_o)
  );

endmodule

// File: hdl/hbm_read_result.sv
//////////////////////////////
// table of outstanding dram reads, matches each completed
// address back to the dma id that asked for it
//////////////////////////////

`timescale 1ns/1ps

module hbm_read_result
  import hbm_bridge_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  // issued requests from execute stage
  input  logic      issue_v_i,
  input  dram_req_s issue_req_i,

  // read completion in simulator order
  input  logic      done_v_i,
  input  ch_addr_u  done_addr_i,

  output logic      rsp_v_o,
  output read_rsp_s rsp_o,
  output logic      full_o
);

  logic [read_slots_c-1:0]    slot_v_q;
  logic [dma_id_width_c-1:0]  slot_id_q   [read_slots_c];
  logic [ch_addr_width_c-1:0] slot_addr_q [read_slots_c];

  logic                        free_found;
  logic [slot_idx_width_c-1:0] free_idx;
  logic                        alloc_v;

  logic [ch_addr_width_c-1:0]  done_key;
  logic                        match_found;
  logic [slot_idx_width_c-1:0] match_idx;
  logic                        release_v;

  //////////////////////////////
  // slot search
  //////////////////////////////

  // lowest free slot
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = 0; i < read_slots_c; i++) begin
      if (!slot_v_q[i] && !free_found) begin
        free_found = 1'b1;
        free_idx   = slot_idx_width_c'(i);
      end
    end
  end

  // returned word back in cache order
  assign done_key = to_cache_order(done_addr_i.dram);

  // lowest valid slot holding the same address
  always_comb begin
    match_found = 1'b0;
    match_idx   = '0;
    for (int i = 0; i < read_slots_c; i++) begin
      if (slot_v_q[i] && slot_addr_q[i] == done_key && !match_found) begin
        match_found = 1'b1;
        match_idx   = slot_idx_width_c'(i);
      end
    end
  end

  // writes never take a slot
  assign alloc_v   = issue_v_i & ~issue_req_i.write & free_found;
  assign release_v = done_v_i & match_found;

  //////////////////////////////
  // table state
  //////////////////////////////

  // alloc and release never hit the same slot in one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_v_q <= '0;
      rsp_v_o  <= 1'b0;
    end else begin
      rsp_v_o <= release_v;
      if (alloc_v) begin
        slot_v_q[free_idx] <= 1'b1;
      end
      if (release_v) begin
        slot_v_q[match_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_v) begin
      slot_id_q[free_idx]   <= issue_req_i.dma_id;
      slot_addr_q[free_idx] <= to_cache_order(issue_req_i.ch_addr);
    end
    if (done_v_i) begin
      rsp_o.dma_id <= slot_id_q[match_idx];
      rsp_o.addr   <= cache_ch_addr_s'(done_key);
    end
  end

  assign full_o = &slot_v_q;

endmodule

// File: hdl/hbm_req_execute.sv
//////////////////////////////
// second bridge stage, reorders the channel address for the
// dram simulator and drives the dram request port
//////////////////////////////

`timescale 1ns/1ps

module hbm_req_execute
  import hbm_bridge_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  // from decode stage
  input  logic      dec_v_i,
  input  dma_req_s  dec_req_i,

  // dram request port, also the issue strobe for the read table
  output logic      dram_req_v_o,
  output dram_req_s dram_req_o
);

  ch_addr_u sim_word;

  // cache order is ba-bg-ro-co-bo, the simulator wants ro-bg-ba-co-bo
  always_comb begin
    sim_word.dram.ro = dec_req_i.addr.cache.ro;
    sim_word.dram.bg = dec_req_i.addr.cache.bg;
    sim_word.dram.ba = dec_req_i.addr.cache.ba;
    sim_word.dram.co = dec_req_i.addr.cache.co;
    sim_word.dram.bo = dec_req_i.addr.cache.bo;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dram_req_v_o <= 1'b0;
    end else begin
      dram_req_v_o <= dec_v_i;
    end
  end

  // payload register
  always_ff @(posedge clk_i) begin
    if (dec_v_i) begin
      dram_req_o.write   <= dec_req_i.write;
      dram_req_o.dma_id  <= dec_req_i.dma_id;
      dram_req_o.ch_addr <= sim_word.dram;
    end
  end

endmodule

// File: hdl/hbm_req_decode.sv
//////////////////////////////
// first bridge stage, registers each request and pulls the
// dma id out of the wormhole header flit
//////////////////////////////

`timescale 1ns/1ps

module hbm_req_decode
  import hbm_bridge_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,

  // requester side
  input  logic       req_v_i,
  input  logic       req_write_i,
  input  wh_header_s req_hdr_i,
  input  ch_addr_u   req_addr_i,

  // to execute stage
  output logic       dec_v_o,
  output dma_req_s   dec_req_o
);

  logic [dma_id_width_c-1:0] dma_id;

  // id sits right above the ruche bits of the source coordinate
  assign dma_id = req_hdr_i.src_cord[lg_ruche_factor_c +: dma_id_width_c];

  //////////////////////////////
  // valid strobe
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_v_o <= 1'b0;
    end else begin
      dec_v_o <= req_v_i;
    end
  end

  //////////////////////////////
  // payload
  //////////////////////////////

  // address still in cache order here
  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      dec_req_o.write  <= req_write_i;
      dec_req_o.dma_id <= dma_id;
      dec_req_o.addr   <= req_addr_i;
    end
  end

endmodule

// File: hdl/hbm_bridge_pkg.sv
//////////////////////////////
// widths and types shared by the cache dma to hbm2 channel bridge
// every bridge module takes it by a wildcard import
//////////////////////////////

package hbm_bridge_pkg;

  // hbm2 channel address fields
  localparam int ba_width_c      = 2;
  localparam int bg_width_c      = 2;
  localparam int ro_width_c      = 14;
  localparam int co_width_c      = 7;
  localparam int bo_width_c      = 5;
  localparam int ch_addr_width_c = ba_width_c + bg_width_c + ro_width_c
                                   + co_width_c + bo_width_c;

  // wormhole header flit
  localparam int cord_width_c      = 8;
  localparam int cid_width_c       = 2;
  localparam int len_width_c       = 4;
  localparam int lg_ruche_factor_c = 1;

  // 8 caches hang off one link
  localparam int dma_id_width_c = 3;

  // outstanding read table
  localparam int read_slots_c     = 4;
  localparam int slot_idx_width_c = 2;

  typedef struct packed {
    logic [cord_width_c-1:0] src_cord;
    logic [cid_width_c-1:0]  cid;
    logic [len_width_c-1:0]  len;
  } wh_header_s;

  // layout as it leaves the cache dma
  typedef struct packed {
    logic [ba_width_c-1:0] ba;
    logic [bg_width_c-1:0] bg;
    logic [ro_width_c-1:0] ro;
    logic [co_width_c-1:0] co;
    logic [bo_width_c-1:0] bo;
  } cache_ch_addr_s;

  // layout the dram simulator expects
  typedef struct packed {
    logic [ro_width_c-1:0] ro;
    logic [bg_width_c-1:0] bg;
    logic [ba_width_c-1:0] ba;
    logic [co_width_c-1:0] co;
    logic [bo_width_c-1:0] bo;
  } dram_ch_addr_s;

  typedef union packed {
    cache_ch_addr_s cache;
    dram_ch_addr_s  dram;
  } ch_addr_u;

  typedef struct packed {
    logic                      write;
    logic [dma_id_width_c-1:0] dma_id;
    ch_addr_u                  addr;
  } dma_req_s;

  typedef struct packed {
    logic                      write;
    logic [dma_id_width_c-1:0] dma_id;
    dram_ch_addr_s             ch_addr;
  } dram_req_s;

  typedef struct packed {
    logic [dma_id_width_c-1:0] dma_id;
    cache_ch_addr_s            addr;
  } read_rsp_s;

  // simulator order back to cache order
  function automatic cache_ch_addr_s to_cache_order(dram_ch_addr_s a);
    cache_ch_addr_s c;
    c.ba = a.ba;
    c.bg = a.bg;
    c.ro = a.ro;
    c.co = a.co;
    c.bo = a.bo;
    return c;
  endfunction

endpackage
